//--- project.f
+incdir+verilog
verilog/bus_pkg.sv
verilog/daq_pkg.sv
verilog/bus_decoder.sv
verilog/system_regs.sv
verilog/control_gpio.sv
verilog/readout_arbiter.sv
verilog/daq_top.sv
test/daq_checker.sv
test/tb_daq_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the DAQ core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_daq_top -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- test/daq_checker.sv
`default_nettype none

`include "daq_defs.svh"

module daq_checker
    import bus_pkg::*, daq_pkg::*;
(
    input  wire                                  BUS_CLK,
    input  wire                                  BUS_RST,
    input  wire bus_addr_t                       bus_add,
    input  wire                                  bus_rd,
    input  wire                                  bus_wr,
    input  wire bus_byte_t                       bus_data_in,
    input  wire bus_byte_t                       bus_data_out,
    input  wire [`CTRL_SENSE_BITS-1:0]           gpio_sense,
    input  wire                                  mgt_ref_sel,
    input  wire [`CTRL_LEMO_BITS-1:0]            lemo_mux,
    input  wire [`CTRL_NTC_BITS-1:0]             ntc_mux,
    input  wire src_vec_t                        src_empty,
    input  wire src_vec_t                        src_hold,
    input  wire src_vec_t                        src_read,
    input  wire fifo_word_t [`ARB_SOURCES-1:0]   src_data,
    input  wire                                  arb_ready,
    input  wire                                  arb_write,
    input  wire fifo_word_t                      arb_data,
    input  wire [7:0]                            test_id,
    input  wire                                  test_end,
    output int                                   check_count,
    output int                                   error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // Model of the writable state
    logic        si570_model;
    logic [15:0] ctrl_model;
    int          ptr_model;
    // Words popped but not yet written out
    fifo_word_t  exp_q [$];
    logic        rd_pending;
    bus_byte_t   rd_expect;
    bus_addr_t   rd_addr;
    logic        pop_last;
    int          errors_before;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            1:       return "system registers";
            2:       return "control gpio";
            3:       return "unmapped access";
            4:       return "round robin";
            5:       return "hold grant";
            6:       return "ready gaps";
            default: return "idle";
        endcase
    endfunction

    // Expected read byte from the address map
    function automatic bus_byte_t register_expect(input bus_addr_t addr, input logic si570,
                                                  input logic [15:0] ctrl,
                                                  input logic [3:0] sense);
        bus_addr_t off;
        register_expect = '0;
        if (addr >= `SYS_BASEADDR && addr <= `SYS_HIGHADDR) begin
            off = addr - `SYS_BASEADDR;
            case (off)
                0:       register_expect = `VERSION_MODULE;
                1:       register_expect = `VERSION_MINOR;
                2:       register_expect = `VERSION_MAJOR;
                3:       register_expect = `BOARD_ID;
                4:       register_expect = {7'd0, si570};
                default: register_expect = '0;
            endcase
        end else if (addr >= `CTRL_BASEADDR && addr <= `CTRL_HIGHADDR) begin
            off = addr - `CTRL_BASEADDR;
            case (off)
                // Input view carries the live sense nibble
                0:       register_expect = {ctrl[7:4], sense};
                1:       register_expect = ctrl[15:8];
                2:       register_expect = ctrl[7:0];
                3:       register_expect = ctrl[15:8];
                default: register_expect = '0;
            endcase
        end
    endfunction

    // First non-empty source from the pointer upward, -1 when all are empty
    function automatic int next_grant(input int ptr, input src_vec_t empty);
        int idx;
        next_grant = -1;
        for (int k = 0; k < `ARB_SOURCES; k++) begin
            idx = (ptr + k) % `ARB_SOURCES;
            if (next_grant < 0 && !empty[idx]) begin
                next_grant = idx;
            end
        end
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("CHECK FAILED test %0d %s: %s expected 0x%0h actual 0x%0h",
                     test_id, test_name(test_id), what, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("ERROR test %0d %s: %s", test_id, test_name(test_id), what);
    endtask

    initial begin
        check_count   = 0;
        error_count   = 0;
        errors_before = 0;
    end

    always @(posedge BUS_CLK) begin
        src_vec_t exp_read;
        int       win;
        if (BUS_RST) begin
            si570_model = 1'b0;
            ctrl_model  = '0;
            ptr_model   = 0;
            rd_pending  = 1'b0;
            pop_last    = 1'b0;
            exp_q.delete();
        end else begin
            // Read data of the previous cycle's read
            if (rd_pending) begin
                compare_value($sformatf("read 0x%0h", rd_addr), 32'(rd_expect),
                              32'(bus_data_out));
            end
            rd_pending = bus_rd;
            if (bus_rd) begin
                rd_addr   = bus_add;
                rd_expect = register_expect(bus_add, si570_model, ctrl_model, gpio_sense);
            end
            // Board outputs follow the register at once
            compare_value("lemo_mux", 32'(ctrl_model[14:7]), 32'(lemo_mux));
            compare_value("ntc_mux", 32'(ctrl_model[6:4]), 32'(ntc_mux));
            compare_value("mgt_ref_sel", 32'(!ctrl_model[15]), 32'(mgt_ref_sel));
            if (bus_wr) begin
                if (bus_add == `SYS_BASEADDR + 5) begin
                    si570_model = bus_data_in[0];
                end else if (bus_add == `CTRL_BASEADDR + 2) begin
                    // Sense nibble is not writable
                    ctrl_model[7:0] = {bus_data_in[7:4], 4'b0000};
                end else if (bus_add == `CTRL_BASEADDR + 3) begin
                    ctrl_model[15:8] = bus_data_in;
                end
            end
            // Output side of the stream
            if (arb_write) begin
                if (!arb_ready) begin
                    report_error("arb_write high while arb_ready is low");
                end
                if (exp_q.size() == 0) begin
                    report_error("arb_write with no popped word pending, duplicate");
                end else begin
                    compare_value("arb_data", exp_q.pop_front(), arb_data);
                end
            end else if (pop_last && arb_ready) begin
                report_error("popped word not written on the cycle after its pop");
            end
            // Pop side, against the grant rule
            win      = arb_ready ? next_grant(ptr_model, src_empty) : -1;
            exp_read = '0;
            if (win >= 0) begin
                exp_read[win] = 1'b1;
            end
            compare_value("src_read", 32'(exp_read), 32'(src_read));
            pop_last = (win >= 0);
            if (win >= 0) begin
                exp_q.push_back(src_data[win]);
                ptr_model = src_hold[win] ? win : (win + 1) % `ARB_SOURCES;
            end
            if (test_end) begin
                if (exp_q.size() != 0) begin
                    report_error($sformatf("%0d popped words never written", exp_q.size()));
                end
                $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                         (error_count == errors_before) ? "pass" : "fail",
                         error_count - errors_before);
                errors_before = error_count;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_daq_top.sv
`default_nettype none

`include "daq_defs.svh"

module tb_daq_top
    import bus_pkg::*, daq_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEPTH         = 64;
    localparam int DRAIN_TIMEOUT = 400;
    localparam int GAP_TIMEOUT   = 2000;

    logic                              BUS_CLK;
    logic                              BUS_RST;
    bus_addr_t                         bus_add;
    logic                              bus_rd;
    logic                              bus_wr;
    bus_byte_t                         bus_data_in;
    bus_byte_t                         bus_data_out;
    logic [`CTRL_SENSE_BITS-1:0]       gpio_sense;
    logic                              mgt_ref_sel;
    logic [`CTRL_LEMO_BITS-1:0]        lemo_mux;
    logic [`CTRL_NTC_BITS-1:0]         ntc_mux;
    src_vec_t                          src_empty;
    src_vec_t                          src_hold;
    src_vec_t                          src_read;
    fifo_word_t [`ARB_SOURCES-1:0]     src_data;
    logic                              arb_ready;
    logic                              arb_write;
    fifo_word_t                        arb_data;
    logic [7:0]                        test_id;
    logic                              test_end;
    int                                check_count;
    int                                error_count;
    int                                timeouts;
    int                                seed;

    // FWFT source FIFOs as plain arrays with head and tail counters
    fifo_word_t fifo_mem [`ARB_SOURCES][DEPTH];
    int         head [`ARB_SOURCES] = '{default: 0};
    int         tail [`ARB_SOURCES] = '{default: 0};

    initial BUS_CLK = 1'b0;
    always #5 BUS_CLK = ~BUS_CLK;

    always_comb begin
        for (int i = 0; i < `ARB_SOURCES; i++) begin
            src_empty[i] = (head[i] == tail[i]);
            src_data[i]  = fifo_mem[i][head[i] % DEPTH];
        end
    end

    // Pop the word the DUT read at this edge
    always @(posedge BUS_CLK) begin
        src_vec_t popped;
        popped = src_read;
        #1;
        for (int i = 0; i < `ARB_SOURCES; i++) begin
            if (!BUS_RST && popped[i]) begin
                head[i] = head[i] + 1;
            end
        end
    end

    daq_top u_daq_top (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .bus_add      (bus_add),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .gpio_sense   (gpio_sense),
        .mgt_ref_sel  (mgt_ref_sel),
        .lemo_mux     (lemo_mux),
        .ntc_mux      (ntc_mux),
        .src_empty    (src_empty),
        .src_hold     (src_hold),
        .src_data     (src_data),
        .src_read     (src_read),
        .arb_ready    (arb_ready),
        .arb_write    (arb_write),
        .arb_data     (arb_data)
    );

    daq_checker u_daq_checker (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .bus_add      (bus_add),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .bus_data_in  (bus_data_in),
        .bus_data_out (bus_data_out),
        .gpio_sense   (gpio_sense),
        .mgt_ref_sel  (mgt_ref_sel),
        .lemo_mux     (lemo_mux),
        .ntc_mux      (ntc_mux),
        .src_empty    (src_empty),
        .src_hold     (src_hold),
        .src_read     (src_read),
        .src_data     (src_data),
        .arb_ready    (arb_ready),
        .arb_write    (arb_write),
        .arb_data     (arb_data),
        .test_id      (test_id),
        .test_end     (test_end),
        .check_count  (check_count),
        .error_count  (error_count)
    );

    task automatic bus_write(input bus_addr_t addr, input bus_byte_t data);
        @(posedge BUS_CLK);
        #1;
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_wr = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr);
        @(posedge BUS_CLK);
        #1;
        bus_add = addr;
        bus_rd  = 1'b1;
        @(posedge BUS_CLK);
        #1;
        bus_rd = 1'b0;
    endtask

    task automatic start_test(input logic [7:0] id);
        @(posedge BUS_CLK);
        #1;
        test_id = id;
    endtask

    task automatic end_test();
        @(posedge BUS_CLK);
        #1;
        test_end = 1'b1;
        @(posedge BUS_CLK);
        #1;
        test_end = 1'b0;
    endtask

    // Random words tagged with the source index in the top nibble
    task automatic fill_fifos(input int count);
        logic [31:0] rnd;
        for (int n = 0; n < count; n++) begin
            for (int i = 0; i < `ARB_SOURCES; i++) begin
                rnd                           = $random(seed);
                fifo_mem[i][tail[i] % DEPTH] = {4'(i), rnd[27:0]};
                tail[i]                       = tail[i] + 1;
            end
        end
    endtask

    // Done when two ready cycles pass with no pop, no write and no data
    task automatic wait_drained(input int limit);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 2 && cycles < limit) begin
            @(posedge BUS_CLK);
            cycles++;
            if ((&src_empty) && !arb_write && (src_read == '0) && arb_ready) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 2) begin
            $display("TIMEOUT: readout stream did not drain within %0d cycles", limit);
            timeouts++;
        end
    endtask

    // Random stalls on the sink until every source is empty
    // Emptiness is sampled at the clock edge
    task automatic stream_with_gaps(input int limit);
        logic [31:0] rnd;
        int          cycles;
        logic        drained;
        cycles  = 0;
        drained = 1'b0;
        while (!drained && cycles < limit) begin
            @(posedge BUS_CLK);
            drained = &src_empty;
            #1;
            rnd       = $random(seed);
            arb_ready = rnd[0];
            cycles++;
        end
        if (!drained) begin
            $display("TIMEOUT: sources not empty after %0d cycles of ready gaps", limit);
            timeouts++;
        end
        arb_ready = 1'b1;
    endtask

    initial begin
        seed        = 32'hfcc3_3b1b;
        timeouts    = 0;
        BUS_RST     = 1'b1;
        bus_add     = '0;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        bus_data_in = '0;
        gpio_sense  = '0;
        src_hold    = '0;
        arb_ready   = 1'b0;
        test_id     = '0;
        test_end    = 1'b0;
        repeat (3) @(posedge BUS_CLK);
        #1;
        BUS_RST = 1'b0;

        start_test(1);
        for (int a = 0; a <= 4; a++) begin
            bus_read(`SYS_BASEADDR + a);
        end
        bus_write(`SYS_BASEADDR + 5, 8'h01);
        bus_read(`SYS_BASEADDR + 4);
        end_test();

        start_test(2);
        gpio_sense = 4'hA;
        bus_write(`CTRL_BASEADDR + 3, 8'hC5);
        bus_write(`CTRL_BASEADDR + 2, 8'hB7);
        for (int a = 0; a <= 3; a++) begin
            bus_read(`CTRL_BASEADDR + a);
        end
        gpio_sense = 4'h5;
        bus_read(`CTRL_BASEADDR);
        // Clearing bit 15 goes back to the internal clock
        bus_write(`CTRL_BASEADDR + 3, 8'h2A);
        bus_read(`CTRL_BASEADDR + 3);
        end_test();

        start_test(3);
        bus_read(32'h0000_0000);
        bus_read(32'h0000_0400);
        bus_read(32'h0000_2EFF);
        bus_read(32'h0000_3000);
        bus_read(32'hFFFF_FFFF);
        bus_write(32'h0000_0405, 8'h00);
        bus_write(32'h0000_02FF, 8'h00);
        bus_write(32'h0000_3003, 8'hFF);
        bus_read(`SYS_BASEADDR + 4);
        bus_read(`CTRL_BASEADDR + 3);
        end_test();

        start_test(4);
        fill_fifos(8);
        arb_ready = 1'b1;
        wait_drained(DRAIN_TIMEOUT);
        end_test();

        start_test(5);
        arb_ready = 1'b0;
        src_hold  = 3'b010;
        fill_fifos(6);
        arb_ready = 1'b1;
        wait_drained(DRAIN_TIMEOUT);
        src_hold = '0;
        end_test();

        start_test(6);
        arb_ready = 1'b0;
        fill_fifos(16);
        stream_with_gaps(GAP_TIMEOUT);
        wait_drained(DRAIN_TIMEOUT);
        end_test();

        $display("SUMMARY: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && check_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/bus_decoder.sv
`default_nettype none

`include "daq_defs.svh"

module bus_decoder
    import bus_pkg::*;
(
    input  wire             BUS_CLK,
    input  wire             BUS_RST,
    input  wire bus_addr_t  bus_add,
    input  wire             bus_rd,
    input  wire             bus_wr,
    input  wire bus_byte_t  sys_data,
    input  wire bus_byte_t  ctrl_data,
    output logic            sys_rd,
    output logic            sys_wr,
    output logic            ctrl_rd,
    output logic            ctrl_wr,
    output bus_addr_t       reg_add,
    output bus_byte_t       bus_data_out
);

    logic       sys_hit;
    logic       ctrl_hit;
    bus_block_t rd_block;

    // Window match on the raw address
    assign sys_hit  = (bus_add >= `SYS_BASEADDR) && (bus_add <= `SYS_HIGHADDR);
    assign ctrl_hit = (bus_add >= `CTRL_BASEADDR) && (bus_add <= `CTRL_HIGHADDR);

    // Block strobes
    assign sys_rd  = bus_rd & sys_hit;
    assign sys_wr  = bus_wr & sys_hit;
    assign ctrl_rd = bus_rd & ctrl_hit;
    assign ctrl_wr = bus_wr & ctrl_hit;

    // Offset inside the hit window
    always_comb begin
        if (sys_hit) begin
            reg_add = bus_add - `SYS_BASEADDR;
        end else if (ctrl_hit) begin
            reg_add = bus_add - `CTRL_BASEADDR;
        end else begin
            reg_add = '0;
        end
    end

    // Remember which block answers the last read
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            rd_block <= BLK_NONE;
        end else if (bus_rd) begin
            if (sys_hit) begin
                rd_block <= BLK_SYS;
            end else if (ctrl_hit) begin
                rd_block <= BLK_CTRL;
            end else begin
                rd_block <= BLK_NONE;
            end
        end
    end

    // Registered byte of the block read last
    // Unmapped reads give 0
    always_comb begin
        case (rd_block)
            BLK_SYS:  bus_data_out = sys_data;
            BLK_CTRL: bus_data_out = ctrl_data;
            default:  bus_data_out = '0;
        endcase
    end

    // Windows must never overlap
    a_one_block: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        !((sys_rd || sys_wr) && (ctrl_rd || ctrl_wr)));

endmodule

`default_nettype wire

//--- verilog/bus_pkg.sv
`default_nettype none

`include "daq_defs.svh"

package bus_pkg;

    // Full bus address, also used for the block-local offset
    typedef logic [`ABUS_WIDTH-1:0] bus_addr_t;

    // One data byte on the bus
    typedef logic [`DBUS_WIDTH-1:0] bus_byte_t;

    // Target of a decoded access
    typedef enum logic [1:0] {
        BLK_NONE = 2'd0,
        BLK_SYS  = 2'd1,
        BLK_CTRL = 2'd2
    } bus_block_t;

endpackage

`default_nettype wire

//--- verilog/control_gpio.sv
`default_nettype none

`include "daq_defs.svh"

module control_gpio
    import bus_pkg::*, daq_pkg::*;
(
    input  wire                          BUS_CLK,
    input  wire                          BUS_RST,
    input  wire                          rd,
    input  wire                          wr,
    input  wire bus_addr_t               reg_add,
    input  wire bus_byte_t               data_in,
    input  wire [`CTRL_SENSE_BITS-1:0]   gpio_sense,
    output bus_byte_t                    data_out,
    output logic                         mgt_ref_sel,
    output logic [`CTRL_LEMO_BITS-1:0]   lemo_mux,
    output logic [`CTRL_NTC_BITS-1:0]    ntc_mux
);

    localparam logic [15:0] OUT_MASK = `CTRL_OUT_MASK;

    ctrl_word_u out_reg;
    ctrl_word_u in_word;

    // Byte writes to the output view
    // Sense bits stay 0
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            out_reg <= '0;
        end else if (wr) begin
            case (reg_add)
                `CTRL_REG_OUT_LO: out_reg.bytes[0] <= data_in & OUT_MASK[7:0];
                `CTRL_REG_OUT_HI: out_reg.bytes[1] <= data_in & OUT_MASK[15:8];
                // Input view is read only
                default: ;
            endcase
        end
    end

    // Input view merges stored outputs with live sense lines
    always_comb begin
        in_word              = out_reg;
        in_word.fields.sense = gpio_sense;
    end

    always_ff @(posedge BUS_CLK) begin
        if (rd) begin
            case (reg_add)
                `CTRL_REG_IN_LO:  data_out <= in_word.bytes[0];
                `CTRL_REG_IN_HI:  data_out <= in_word.bytes[1];
                `CTRL_REG_OUT_LO: data_out <= out_reg.bytes[0];
                `CTRL_REG_OUT_HI: data_out <= out_reg.bytes[1];
                default:          data_out <= '0;
            endcase
        end
    end

    // Board outputs straight from the register
    // Cleared bit 15 selects the internal reference clock
    assign mgt_ref_sel = ~out_reg.fields.clk_sel;
    assign lemo_mux    = out_reg.fields.lemo_mux;
    assign ntc_mux     = out_reg.fields.ntc_mux;

endmodule

`default_nettype wire

//--- verilog/daq_defs.svh
`ifndef DAQ_DEFS_SVH
`define DAQ_DEFS_SVH

// Local bus widths
`define ABUS_WIDTH 32
`define DBUS_WIDTH 8

// Address windows, both bounds inclusive
`define SYS_BASEADDR  32'h0000_0300
`define SYS_HIGHADDR  32'h0000_03FF
`define CTRL_BASEADDR 32'h0000_2F00
`define CTRL_HIGHADDR 32'h0000_2FFF

// Firmware version readback
`define VERSION_MODULE 8'd1
`define VERSION_MINOR  8'd0
`define VERSION_MAJOR  8'd0

// Board identity, 0 is the simulation board
`define BOARD_ID 8'd0

// System register offsets
`define SYS_REG_VERSION   0
`define SYS_REG_MINOR     1
`define SYS_REG_MAJOR     2
`define SYS_REG_BOARD     3
`define SYS_REG_SI570     4
`define SYS_REG_SI570_SET 5

// Control GPIO offsets, input view then output view
`define CTRL_REG_IN_LO  0
`define CTRL_REG_IN_HI  1
`define CTRL_REG_OUT_LO 2
`define CTRL_REG_OUT_HI 3

// Writable control bits, the sense nibble is input only
`define CTRL_OUT_MASK 16'hFFF0

// Control word fields, packed from bit 15 down
// Clock select 15, LEMO mux 14:7, NTC mux 6:4, sense 3:0
`define CTRL_LEMO_BITS  8
`define CTRL_NTC_BITS   3
`define CTRL_SENSE_BITS 4

// Readout sources and word width
`define ARB_SOURCES 3
`define FIFO_WIDTH  32

`endif

//--- verilog/daq_pkg.sv
`default_nettype none

`include "daq_defs.svh"

package daq_pkg;

    // Board control fields, MSB first
    typedef struct packed {
        logic                        clk_sel;
        logic [`CTRL_LEMO_BITS-1:0]  lemo_mux;
        logic [`CTRL_NTC_BITS-1:0]   ntc_mux;
        logic [`CTRL_SENSE_BITS-1:0] sense;
    } ctrl_fields_t;

    // Same 16 bits seen by the bus as bytes
    // and by the board outputs as fields
    typedef union packed {
        logic [1:0][`DBUS_WIDTH-1:0] bytes;
        ctrl_fields_t                fields;
    } ctrl_word_u;

    // One readout word from a source FIFO
    typedef logic [`FIFO_WIDTH-1:0] fifo_word_t;

    // One bit per source
    // request, hold and read strobes
    typedef logic [`ARB_SOURCES-1:0] src_vec_t;

endpackage

`default_nettype wire

//--- verilog/daq_top.sv
`default_nettype none

`include "daq_defs.svh"

module daq_top
    import bus_pkg::*, daq_pkg::*;
(
    input  wire                                  BUS_CLK,
    input  wire                                  BUS_RST,
    // Local bus
    input  wire bus_addr_t                       bus_add,
    input  wire                                  bus_rd,
    input  wire                                  bus_wr,
    input  wire bus_byte_t                       bus_data_in,
    output bus_byte_t                            bus_data_out,
    // Board control
    input  wire [`CTRL_SENSE_BITS-1:0]           gpio_sense,
    output logic                                 mgt_ref_sel,
    output logic [`CTRL_LEMO_BITS-1:0]           lemo_mux,
    output logic [`CTRL_NTC_BITS-1:0]            ntc_mux,
    // Source FIFOs, FWFT
    input  wire src_vec_t                        src_empty,
    input  wire src_vec_t                        src_hold,
    input  wire fifo_word_t [`ARB_SOURCES-1:0]   src_data,
    output src_vec_t                             src_read,
    // Merged output stream
    input  wire                                  arb_ready,
    output logic                                 arb_write,
    output fifo_word_t                           arb_data
);

    logic      sys_rd;
    logic      sys_wr;
    logic      ctrl_rd;
    logic      ctrl_wr;
    bus_addr_t reg_add;
    bus_byte_t sys_data;
    bus_byte_t ctrl_data;

    bus_decoder u_bus_decoder (
        .BUS_CLK      (BUS_CLK),
        .BUS_RST      (BUS_RST),
        .bus_add      (bus_add),
        .bus_rd       (bus_rd),
        .bus_wr       (bus_wr),
        .sys_data     (sys_data),
        .ctrl_data    (ctrl_data),
        .sys_rd       (sys_rd),
        .sys_wr       (sys_wr),
        .ctrl_rd      (ctrl_rd),
        .ctrl_wr      (ctrl_wr),
        .reg_add      (reg_add),
        .bus_data_out (bus_data_out)
    );

    // Version, board identity and clock flag
    system_regs u_system_regs (
        .BUS_CLK  (BUS_CLK),
        .BUS_RST  (BUS_RST),
        .rd       (sys_rd),
        .wr       (sys_wr),
        .reg_add  (reg_add),
        .data_in  (bus_data_in),
        .data_out (sys_data)
    );

    control_gpio u_control_gpio (
        .BUS_CLK     (BUS_CLK),
        .BUS_RST     (BUS_RST),
        .rd          (ctrl_rd),
        .wr          (ctrl_wr),
        .reg_add     (reg_add),
        .data_in     (bus_data_in),
        .gpio_sense  (gpio_sense),
        .data_out    (ctrl_data),
        .mgt_ref_sel (mgt_ref_sel),
        .lemo_mux    (lemo_mux),
        .ntc_mux     (ntc_mux)
    );

    // Source 1 is the one that may hold the grant
    readout_arbiter u_readout_arbiter (
        .BUS_CLK   (BUS_CLK),
        .BUS_RST   (BUS_RST),
        .src_empty (src_empty),
        .src_hold  (src_hold),
        .src_data  (src_data),
        .arb_ready (arb_ready),
        .src_read  (src_read),
        .arb_write (arb_write),
        .arb_data  (arb_data)
    );

endmodule

`default_nettype wire

//--- verilog/readout_arbiter.sv
`default_nettype none

`include "daq_defs.svh"

module readout_arbiter
    import daq_pkg::*;
(
    input  wire                                  BUS_CLK,
    input  wire                                  BUS_RST,
    input  wire src_vec_t                        src_empty,
    input  wire src_vec_t                        src_hold,
    input  wire fifo_word_t [`ARB_SOURCES-1:0]   src_data,
    input  wire                                  arb_ready,
    output src_vec_t                             src_read,
    output logic                                 arb_write,
    output fifo_word_t                           arb_data
);

    localparam int PTR_W = $clog2(`ARB_SOURCES);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] winner;
    logic [PTR_W-1:0] winner_next;
    logic             grant_any;
    logic             pop;
    // Popped word waiting for the sink
    logic             word_valid;

    // First non-empty source at or after the pointer, with wrap
    always_comb begin
        int idx;
        grant_any = 1'b0;
        winner    = ptr;
        for (int k = 0; k < `ARB_SOURCES; k++) begin
            idx = int'(ptr) + k;
            if (idx >= `ARB_SOURCES) begin
                idx = idx - `ARB_SOURCES;
            end
            if (!grant_any && !src_empty[idx]) begin
                grant_any = 1'b1;
                winner    = PTR_W'(idx);
            end
        end
    end

    // Pointer after a grant without hold
    assign winner_next = (winner == PTR_W'(`ARB_SOURCES - 1)) ? '0 : winner + 1'b1;

    // No pops while the sink stalls
    assign pop = arb_ready & grant_any;

    always_comb begin
        src_read = '0;
        if (pop) begin
            src_read[winner] = 1'b1;
        end
    end

    // Rotation, a held source keeps the pointer
    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            ptr        <= '0;
            word_valid <= 1'b0;
        end else begin
            if (pop) begin
                ptr <= src_hold[winner] ? winner : winner_next;
            end
            // New word replaces the one written this cycle
            if (pop) begin
                word_valid <= 1'b1;
            end else if (arb_ready) begin
                word_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (pop) begin
            arb_data <= src_data[winner];
        end
    end

    // Held word goes out once the sink is ready again
    assign arb_write = word_valid & arb_ready;

    a_read_onehot: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        $onehot0(src_read));

    // FWFT data is only valid while the FIFO is non-empty
    a_no_empty_pop: assert property (@(posedge BUS_CLK) disable iff (BUS_RST)
        (src_read & src_empty) == '0);

endmodule

`default_nettype wire

//--- verilog/system_regs.sv
`default_nettype none

`include "daq_defs.svh"

module system_regs
    import bus_pkg::*;
(
    input  wire             BUS_CLK,
    input  wire             BUS_RST,
    input  wire             rd,
    input  wire             wr,
    input  wire bus_addr_t  reg_add,
    input  wire bus_byte_t  data_in,
    output bus_byte_t       data_out
);

    // Set by software once the reference clock chip is programmed
    logic si570_configured;

    always_ff @(posedge BUS_CLK) begin
        if (BUS_RST) begin
            si570_configured <= 1'b0;
        end else if (wr && (reg_add == `SYS_REG_SI570_SET)) begin
            // Only bit 0 carries the flag
            si570_configured <= data_in[0];
        end
    end

    // Readback byte, held until the next read
    always_ff @(posedge BUS_CLK) begin
        if (rd) begin
            case (reg_add)
                `SYS_REG_VERSION: data_out <= `VERSION_MODULE;
                `SYS_REG_MINOR:   data_out <= `VERSION_MINOR;
                `SYS_REG_MAJOR:   data_out <= `VERSION_MAJOR;
                `SYS_REG_BOARD:   data_out <= `BOARD_ID;
                `SYS_REG_SI570: begin
                    data_out <= {{(`DBUS_WIDTH-1){1'b0}}, si570_configured};
                end
                // Write-only and unused offsets
                default:          data_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire
